// File: wtc_dcache.f
source/wtc_pkg.sv
source/wtc_cache_mem.sv
source/wtc_load_ctrl.sv
source/wtc_store_ctrl.sv
source/wtc_miss_unit.sv
source/wtc_dcache.sv
tests/tb_clock_gen.sv
tests/tb_mem_model.sv
tests/tb_wtc_dcache.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_wtc_dcache
RTL_TOP    = wtc_dcache
FILELIST   = wtc_dcache.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_wtc_dcache.sv
`timescale 1ns/10ps

module tb_wtc_dcache import wtc_pkg::*; ();

  localparam int    N_RAND        = 300;
  localparam int    N_OPS         = N_RAND + 40;
  localparam int    CYCLES_PER_OP = 200;
  localparam int    RESET_CYCLES  = 10;
  localparam int    DRIVE_DLY     = 10;
  localparam int    LINE_BYTES    = LINE_WORDS * 4;
  localparam addr_t A_HOT         = 16'h0124;
  localparam addr_t A_HOT_NEXT    = 16'h0128;
  localparam addr_t A_COLD        = 16'h0a40;

  typedef logic [ADDR_W-3:0] widx_t;

  logic            clk;
  logic            rst_n;
  logic            ld_valid;
  addr_t           ld_addr;
  logic            ld_ready;
  logic            ld_rvalid;
  word_t           ld_rdata;
  logic            st_valid;
  addr_t           st_addr;
  word_t           st_data;
  logic [BE_W-1:0] st_be;
  logic            st_ready;
  logic            mem_valid;
  logic            mem_we;
  addr_t           mem_addr;
  word_t           mem_wdata;
  logic [BE_W-1:0] mem_be;
  logic            mem_ready;
  logic            mem_rvalid;
  word_t           mem_rdata;
  logic            flush;
  logic            flush_ack;
  logic            miss;
  logic            stall_en;

  // reference state: memory image, tags and valid bits
  word_t image [widx_t];
  tag_t  line_tag [NUM_LINES];
  logic  line_valid [NUM_LINES];

  word_t exp_data_q [$];
  logic  exp_miss_q [$];
  string exp_name_q [$];
  string resp_name;
  int    miss_seen = 0;
  int    errors = 0;
  int    checks = 0;
  int    loads_done = 0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tb_mem_model u_mem (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .stall_en_i   (stall_en),
    .mem_valid_i  (mem_valid),
    .mem_we_i     (mem_we),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_be_i     (mem_be),
    .mem_ready_o  (mem_ready),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  wtc_dcache u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .ld_valid_i   (ld_valid),
    .ld_addr_i    (ld_addr),
    .ld_ready_o   (ld_ready),
    .ld_rvalid_o  (ld_rvalid),
    .ld_rdata_o   (ld_rdata),
    .st_valid_i   (st_valid),
    .st_addr_i    (st_addr),
    .st_data_i    (st_data),
    .st_be_i      (st_be),
    .st_ready_o   (st_ready),
    .mem_valid_o  (mem_valid),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .mem_ready_i  (mem_ready),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .flush_i      (flush),
    .flush_ack_o  (flush_ack),
    .miss_o       (miss)
  );

  ////////////////////////////////////////////////////////////
  // reference cache model
  ////////////////////////////////////////////////////////////

  function automatic word_t fill_word(widx_t widx);
    return {2'b10, widx, 2'b01, ~widx};
  endfunction

  function automatic word_t image_word(widx_t widx);
    if (image.exists(widx)) begin
      return image[widx];
    end
    return fill_word(widx);
  endfunction

  // direct mapped, a miss brings the whole line in
  function automatic word_t expect_load(addr_t a, output logic was_miss);
    idx_t idx;
    tag_t tag;
    idx = idx_t'((a / LINE_BYTES) % NUM_LINES);
    tag = tag_t'(a / (LINE_BYTES * NUM_LINES));
    was_miss = !(line_valid[idx] && line_tag[idx] == tag);
    line_valid[idx] = 1'b1;
    line_tag[idx] = tag;
    return image_word(a[ADDR_W-1:2]);
  endfunction

  // write-through, no allocate, so tags stay as they are
  function automatic void apply_store(addr_t a, word_t d, logic [BE_W-1:0] be);
    word_t w;
    w = image_word(a[ADDR_W-1:2]);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    image[a[ADDR_W-1:2]] = w;
  endfunction

  function automatic void clear_lines();
    for (int i = 0; i < NUM_LINES; i++) begin
      line_valid[i] = 1'b0;
    end
  endfunction

  function automatic addr_t rand_addr();
    int unsigned line_no;
    int unsigned word_no;
    line_no = ($urandom % 3) * NUM_LINES + ($urandom % 4);
    word_no = $urandom % LINE_WORDS;
    return addr_t'(line_no * LINE_BYTES + word_no * 4);
  endfunction

  task automatic check_val(string name, word_t exp, word_t act);
    checks++;
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic load_word(string name, addr_t a);
    word_t exp;
    logic  exp_miss;
    @(posedge clk);
    #DRIVE_DLY;
    ld_valid = 1'b1;
    ld_addr  = a;
    @(negedge clk);
    while (!ld_ready) @(negedge clk);
    exp = expect_load(a, exp_miss);
    exp_data_q.push_back(exp);
    exp_miss_q.push_back(exp_miss);
    exp_name_q.push_back(name);
    @(posedge clk);
    #DRIVE_DLY ld_valid = 1'b0;
    // back to idle once the response is out
    @(negedge clk);
    while (!ld_ready) @(negedge clk);
  endtask

  task automatic store_word(addr_t a, word_t d, logic [BE_W-1:0] be);
    @(posedge clk);
    #DRIVE_DLY;
    st_valid = 1'b1;
    st_addr  = a;
    st_data  = d;
    st_be    = be;
    @(negedge clk);
    while (!st_ready) @(negedge clk);
    apply_store(a, d, be);
    @(posedge clk);
    #DRIVE_DLY st_valid = 1'b0;
  endtask

  task automatic flush_cache(string name);
    logic acked;
    @(posedge clk);
    #DRIVE_DLY flush = 1'b1;
    acked = 1'b0;
    while (!acked) begin
      @(negedge clk);
      check_val({name, " ld_ready"}, 32'd0, word_t'(ld_ready));
      check_val({name, " st_ready"}, 32'd0, word_t'(st_ready));
      acked = flush_ack;
    end
    clear_lines();
    @(posedge clk);
    #DRIVE_DLY flush = 1'b0;
  endtask

  // compare process, every response against the queued expectation
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (flush_ack && !flush) begin
          $display("ERROR: flush acknowledge without a flush request");
          errors++;
        end
        if (miss) begin
          miss_seen++;
        end
        if (ld_rvalid) begin
          if (exp_data_q.size() == 0) begin
            $display("ERROR: load response with no load outstanding");
            errors++;
          end else begin
            resp_name = exp_name_q.pop_front();
            check_val({resp_name, " data"}, exp_data_q.pop_front(), ld_rdata);
            check_val({resp_name, " miss"}, word_t'(exp_miss_q.pop_front()),
                      word_t'(miss_seen));
            loads_done++;
          end
          miss_seen = 0;
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + N_OPS * CYCLES_PER_OP) @(posedge clk);
    $display("ERROR: watchdog expired, the run took too many cycles");
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned op;
    addr_t       a;
    logic [BE_W-1:0] be;
    void'($urandom(32'h2cbd));
    ld_valid = 1'b0;
    ld_addr  = '0;
    st_valid = 1'b0;
    st_addr  = '0;
    st_data  = '0;
    st_be    = '0;
    flush    = 1'b0;
    stall_en = 1'b0;
    clear_lines();

    @(posedge rst_n);
    @(negedge clk);
    check_val("reset ld_rvalid", 32'd0, word_t'(ld_rvalid));
    check_val("reset miss", 32'd0, word_t'(miss));
    check_val("reset mem_valid", 32'd0, word_t'(mem_valid));
    check_val("reset flush_ack", 32'd0, word_t'(flush_ack));
    check_val("reset ld_ready", 32'd1, word_t'(ld_ready));
    check_val("reset st_ready", 32'd1, word_t'(st_ready));

    load_word("first_load", A_HOT);
    load_word("second_load", A_HOT);
    load_word("same_line_load", A_HOT_NEXT);

    // partial store into a cached word
    store_word(A_HOT_NEXT, 32'hdead_beef, 4'b0110);
    load_word("merge_load", A_HOT_NEXT);
    check_val("merge_mem", image_word(A_HOT_NEXT[ADDR_W-1:2]),
              u_mem.mem[A_HOT_NEXT[ADDR_W-1:2]]);

    store_word(A_COLD, 32'h1234_5678, 4'b1111);
    load_word("uncached_load", A_COLD);

    flush_cache("flush");
    load_word("post_flush_hot", A_HOT);
    load_word("post_flush_cold", A_COLD);

    stall_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      op = $urandom % 10;
      a  = rand_addr();
      if (op < 5) begin
        load_word($sformatf("rand_%0d", i), a);
      end else begin
        be = BE_W'(($urandom % 15) + 1);
        store_word(a, word_t'($urandom), be);
      end
    end
    stall_en = 1'b0;

    repeat (5) @(negedge clk);
    if (exp_data_q.size() != 0) begin
      $display("ERROR: %0d load responses never arrived", exp_data_q.size());
      errors++;
    end
    $display("loads %0d, checks %0d, errors %0d", loads_done, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model import wtc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            stall_en_i,
  input  logic            mem_valid_i,
  input  logic            mem_we_i,
  input  addr_t           mem_addr_i,
  input  word_t           mem_wdata_i,
  input  logic [BE_W-1:0] mem_be_i,
  output logic            mem_ready_o,
  output logic            mem_rvalid_o,
  output word_t           mem_rdata_o
);

  localparam int WORDS     = 2 ** (ADDR_W - 2);
  localparam int DRIVE_DLY = 10;

  typedef logic [ADDR_W-3:0] widx_t;

  word_t           mem [WORDS];
  word_t           beats_q [$];
  logic            take_req = 1'b0;
  logic            take_we;
  widx_t           take_widx;
  word_t           take_wdata;
  logic [BE_W-1:0] take_be;
  widx_t           base;

  // every word address gets its own value
  function automatic word_t fill_word(widx_t widx);
    return {2'b10, widx, 2'b01, ~widx};
  endfunction

  // handshake sampled at the falling edge, where it is stable
  initial begin
    forever begin
      @(negedge clk_i);
      take_req   = rst_n_i && mem_valid_i && mem_ready_o;
      take_we    = mem_we_i;
      take_widx  = mem_addr_i[ADDR_W-1:2];
      take_wdata = mem_wdata_i;
      take_be    = mem_be_i;
    end
  end

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = fill_word(widx_t'(i));
    end
    mem_ready_o  = 1'b1;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      if (take_req && take_we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (take_be[b]) begin
            mem[take_widx][8*b +: 8] = take_wdata[8*b +: 8];
          end
        end
      end else if (take_req) begin
        // whole line queued in word order
        base = take_widx & ~widx_t'(LINE_WORDS - 1);
        for (int w = 0; w < LINE_WORDS; w++) begin
          beats_q.push_back(mem[base + widx_t'(w)]);
        end
      end
      if (beats_q.size() != 0 && (!stall_en_i || ($urandom % 4) != 0)) begin
        mem_rvalid_o = 1'b1;
        mem_rdata_o  = beats_q.pop_front();
      end else begin
        mem_rvalid_o = 1'b0;
      end
      mem_ready_o = !stall_en_i || (($urandom % 4) != 0);
    end
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DLY    = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset drops just after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #DRIVE_DLY rst_n_o = 1'b1;
  end

endmodule

// File: source/wtc_dcache.sv
`timescale 1ns/10ps

module wtc_dcache import wtc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // load port
  input  logic            ld_valid_i,
  input  addr_t           ld_addr_i,
  output logic            ld_ready_o,
  output logic            ld_rvalid_o,
  output word_t           ld_rdata_o,
  // store port
  input  logic            st_valid_i,
  input  addr_t           st_addr_i,
  input  word_t           st_data_i,
  input  logic [BE_W-1:0] st_be_i,
  output logic            st_ready_o,
  // memory port
  output logic            mem_valid_o,
  output logic            mem_we_o,
  output addr_t           mem_addr_o,
  output word_t           mem_wdata_o,
  output logic [BE_W-1:0] mem_be_o,
  input  logic            mem_ready_i,
  input  logic            mem_rvalid_i,
  input  word_t           mem_rdata_i,
  // management
  input  logic            flush_i,
  output logic            flush_ack_o,
  output logic            miss_o
);

  // load side <-> arrays
  idx_t            lk_idx;
  tag_t            lk_tag;
  off_t            lk_off;
  logic            lk_hit;
  word_t           lk_data;
  // store side <-> arrays
  idx_t            sk_idx;
  tag_t            sk_tag;
  logic            sk_hit;
  logic            word_we;
  idx_t            word_idx;
  off_t            word_off;
  word_t           word_data;
  logic [BE_W-1:0] word_be;
  // controllers <-> miss unit
  logic            refill_req;
  addr_t           refill_addr;
  logic            refill_gnt;
  logic            refill_done;
  logic            wt_req;
  addr_t           wt_addr;
  word_t           wt_data;
  logic [BE_W-1:0] wt_be;
  logic            wt_gnt;
  logic            st_busy;
  // miss unit <-> arrays
  logic            refill_we;
  logic            refill_last;
  idx_t            refill_idx;
  tag_t            refill_tag;
  off_t            refill_off;
  word_t           refill_data;
  logic            flush_clr;

  ////////////////////////////////////////////////////////////
  // load controller
  ////////////////////////////////////////////////////////////

  wtc_load_ctrl i_wtc_load_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ld_valid_i    (ld_valid_i),
    .ld_addr_i     (ld_addr_i),
    .ld_ready_o    (ld_ready_o),
    .ld_rvalid_o   (ld_rvalid_o),
    .ld_rdata_o    (ld_rdata_o),
    .miss_o        (miss_o),
    .flush_i       (flush_i),
    .st_busy_i     (st_busy),
    .lk_idx_o      (lk_idx),
    .lk_tag_o      (lk_tag),
    .lk_off_o      (lk_off),
    .lk_hit_i      (lk_hit),
    .lk_data_i     (lk_data),
    .refill_req_o  (refill_req),
    .refill_addr_o (refill_addr),
    .refill_gnt_i  (refill_gnt),
    .refill_done_i (refill_done),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  ////////////////////////////////////////////////////////////
  // store controller
  ////////////////////////////////////////////////////////////

  wtc_store_ctrl i_wtc_store_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .st_valid_i  (st_valid_i),
    .st_addr_i   (st_addr_i),
    .st_data_i   (st_data_i),
    .st_be_i     (st_be_i),
    .st_ready_o  (st_ready_o),
    .st_busy_o   (st_busy),
    .flush_i     (flush_i),
    .sk_idx_o    (sk_idx),
    .sk_tag_o    (sk_tag),
    .sk_hit_i    (sk_hit),
    .word_we_o   (word_we),
    .word_idx_o  (word_idx),
    .word_off_o  (word_off),
    .word_data_o (word_data),
    .word_be_o   (word_be),
    .wt_req_o    (wt_req),
    .wt_addr_o   (wt_addr),
    .wt_data_o   (wt_data),
    .wt_be_o     (wt_be),
    .wt_gnt_i    (wt_gnt)
  );

  ////////////////////////////////////////////////////////////
  // miss unit
  ////////////////////////////////////////////////////////////

  wtc_miss_unit i_wtc_miss_unit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .refill_req_i  (refill_req),
    .refill_addr_i (refill_addr),
    .refill_gnt_o  (refill_gnt),
    .refill_done_o (refill_done),
    .wt_req_i      (wt_req),
    .wt_addr_i     (wt_addr),
    .wt_data_i     (wt_data),
    .wt_be_i       (wt_be),
    .wt_gnt_o      (wt_gnt),
    .flush_i       (flush_i),
    .st_busy_i     (st_busy),
    .flush_clr_o   (flush_clr),
    .flush_ack_o   (flush_ack_o),
    .mem_valid_o   (mem_valid_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_be_o      (mem_be_o),
    .mem_ready_i   (mem_ready_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .refill_we_o   (refill_we),
    .refill_last_o (refill_last),
    .refill_idx_o  (refill_idx),
    .refill_tag_o  (refill_tag),
    .refill_off_o  (refill_off),
    .refill_data_o (refill_data)
  );

  ////////////////////////////////////////////////////////////
  // tag, valid and data arrays
  ////////////////////////////////////////////////////////////

  wtc_cache_mem i_wtc_cache_mem (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lk_idx_i      (lk_idx),
    .lk_tag_i      (lk_tag),
    .lk_off_i      (lk_off),
    .lk_hit_o      (lk_hit),
    .lk_data_o     (lk_data),
    .sk_idx_i      (sk_idx),
    .sk_tag_i      (sk_tag),
    .sk_hit_o      (sk_hit),
    .word_we_i     (word_we),
    .word_idx_i    (word_idx),
    .word_off_i    (word_off),
    .word_data_i   (word_data),
    .word_be_i     (word_be),
    .refill_we_i   (refill_we),
    .refill_last_i (refill_last),
    .refill_idx_i  (refill_idx),
    .refill_tag_i  (refill_tag),
    .refill_off_i  (refill_off),
    .refill_data_i (refill_data),
    .flush_clr_i   (flush_clr)
  );

endmodule

// File: source/wtc_miss_unit.sv
`timescale 1ns/10ps

module wtc_miss_unit import wtc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // load side
  input  logic            refill_req_i,
  input  addr_t           refill_addr_i,
  output logic            refill_gnt_o,
  output logic            refill_done_o,
  // store side
  input  logic            wt_req_i,
  input  addr_t           wt_addr_i,
  input  word_t           wt_data_i,
  input  logic [BE_W-1:0] wt_be_i,
  output logic            wt_gnt_o,
  // flush
  input  logic            flush_i,
  input  logic            st_busy_i,
  output logic            flush_clr_o,
  output logic            flush_ack_o,
  // memory port
  output logic            mem_valid_o,
  output logic            mem_we_o,
  output addr_t           mem_addr_o,
  output word_t           mem_wdata_o,
  output logic [BE_W-1:0] mem_be_o,
  input  logic            mem_ready_i,
  input  logic            mem_rvalid_i,
  input  word_t           mem_rdata_i,
  // refill write into the arrays
  output logic            refill_we_o,
  output logic            refill_last_o,
  output idx_t            refill_idx_o,
  output tag_t            refill_tag_o,
  output off_t            refill_off_o,
  output word_t           refill_data_o
);

  typedef enum logic [1:0] {
    MU_IDLE,
    MU_WRITE,
    MU_READ,
    MU_BEATS
  } mu_state_e;

  mu_state_e state_q;
  off_t      beat_q;
  idx_t      idx_q;
  tag_t      tag_q;
  logic      done_q;
  logic      flush_go;

  // flush with nothing in flight on either side
  assign flush_go = (state_q == MU_IDLE) && flush_i && !st_busy_i &&
                    !wt_req_i && !refill_req_i;
  assign flush_clr_o = flush_go;
  assign flush_ack_o = flush_go;

  ////////////////////////////////////////////////////////////
  // memory request
  ////////////////////////////////////////////////////////////

  assign mem_valid_o = (state_q == MU_WRITE) || (state_q == MU_READ);
  assign mem_we_o    = (state_q == MU_WRITE);
  assign mem_addr_o  = (state_q == MU_WRITE) ? {wt_addr_i[ADDR_W-1:2], 2'b00}
                                             : line_base(refill_addr_i);
  assign mem_wdata_o = wt_data_i;
  assign mem_be_o    = (state_q == MU_WRITE) ? wt_be_i : '1;

  assign wt_gnt_o     = (state_q == MU_WRITE) && mem_ready_i;
  assign refill_gnt_o = (state_q == MU_READ) && mem_ready_i;

  // beats land in word order
  assign refill_we_o   = (state_q == MU_BEATS) && mem_rvalid_i;
  assign refill_last_o = (beat_q == off_t'(LINE_WORDS - 1));
  assign refill_idx_o  = idx_q;
  assign refill_tag_o  = tag_q;
  assign refill_off_o  = beat_q;
  assign refill_data_o = mem_rdata_i;
  assign refill_done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MU_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= refill_we_o && refill_last_o;
      case (state_q)
        MU_IDLE: begin
          // write-through first
          if (wt_req_i) begin
            state_q <= MU_WRITE;
          end else if (refill_req_i) begin
            state_q <= MU_READ;
          end
        end
        MU_WRITE: begin
          if (mem_ready_i) begin
            state_q <= MU_IDLE;
          end
        end
        MU_READ: begin
          if (mem_ready_i) begin
            state_q <= MU_BEATS;
            beat_q  <= '0;
          end
        end
        MU_BEATS: begin
          if (refill_we_o) begin
            beat_q <= beat_q + 1'b1;
            if (refill_last_o) begin
              state_q <= MU_IDLE;
            end
          end
        end
        default: state_q <= MU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_gnt_o) begin
      idx_q <= addr_idx(refill_addr_i);
      tag_q <= addr_tag(refill_addr_i);
    end
  end

  a_rvalid_in_refill : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> (state_q == MU_BEATS))
    else $error("memory read beat outside an open refill");

endmodule

// File: source/wtc_store_ctrl.sv
`timescale 1ns/10ps

module wtc_store_ctrl import wtc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            st_valid_i,
  input  addr_t           st_addr_i,
  input  word_t           st_data_i,
  input  logic [BE_W-1:0] st_be_i,
  output logic            st_ready_o,
  output logic            st_busy_o,
  input  logic            flush_i,
  // hit check and word write
  output idx_t            sk_idx_o,
  output tag_t            sk_tag_o,
  input  logic            sk_hit_i,
  output logic            word_we_o,
  output idx_t            word_idx_o,
  output off_t            word_off_o,
  output word_t           word_data_o,
  output logic [BE_W-1:0] word_be_o,
  // write-through to the miss unit
  output logic            wt_req_o,
  output addr_t           wt_addr_o,
  output word_t           wt_data_o,
  output logic [BE_W-1:0] wt_be_o,
  input  logic            wt_gnt_i
);

  logic            busy_q;
  logic            first_q;
  addr_t           addr_q;
  word_t           data_q;
  logic [BE_W-1:0] be_q;
  logic            accept;

  assign st_ready_o = !busy_q && !flush_i;
  assign accept     = st_valid_i && st_ready_o;
  assign st_busy_o  = busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      first_q <= 1'b0;
    end else begin
      first_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (wt_gnt_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= st_addr_i;
      data_q <= st_data_i;
      be_q   <= st_be_i;
    end
  end

  assign sk_idx_o = addr_idx(addr_q);
  assign sk_tag_o = addr_tag(addr_q);

  // no-allocate, only a present line is updated
  // a refill that finished while this store waited is patched again at grant
  assign word_we_o   = busy_q && sk_hit_i && (first_q || wt_gnt_i);
  assign word_idx_o  = addr_idx(addr_q);
  assign word_off_o  = addr_off(addr_q);
  assign word_data_o = data_q;
  assign word_be_o   = be_q;

  // held until the memory write transfers
  assign wt_req_o  = busy_q;
  assign wt_addr_o = addr_q;
  assign wt_data_o = data_q;
  assign wt_be_o   = be_q;

endmodule

// File: source/wtc_load_ctrl.sv
`timescale 1ns/10ps

module wtc_load_ctrl import wtc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  ld_valid_i,
  input  addr_t ld_addr_i,
  output logic  ld_ready_o,
  output logic  ld_rvalid_o,
  output word_t ld_rdata_o,
  output logic  miss_o,
  input  logic  flush_i,
  input  logic  st_busy_i,
  // cache lookup
  output idx_t  lk_idx_o,
  output tag_t  lk_tag_o,
  output off_t  lk_off_o,
  input  logic  lk_hit_i,
  input  word_t lk_data_i,
  // miss unit
  output logic  refill_req_o,
  output addr_t refill_addr_o,
  input  logic  refill_gnt_i,
  input  logic  refill_done_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i
);

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_LOOKUP,
    LD_REFILL,
    LD_RESP
  } ld_state_e;

  ld_state_e state_q;
  addr_t     addr_q;
  word_t     rdata_q;
  logic      req_q;
  off_t      beat_q;
  logic      ld_open_q;
  addr_t     lk_addr;
  logic      accept;
  logic      beat;

  // one load in flight, none while a store or a flush is open
  assign ld_ready_o = (state_q == LD_IDLE) && !flush_i && !st_busy_i;
  assign accept     = ld_valid_i && ld_ready_o;

  // lookup goes out on the accepting edge
  assign lk_addr  = (state_q == LD_IDLE) ? ld_addr_i : addr_q;
  assign lk_idx_o = addr_idx(lk_addr);
  assign lk_tag_o = addr_tag(lk_addr);
  assign lk_off_o = addr_off(lk_addr);

  assign miss_o        = (state_q == LD_LOOKUP) && !lk_hit_i;
  assign refill_req_o  = req_q;
  assign refill_addr_o = addr_q;
  assign beat          = (state_q == LD_REFILL) && !req_q && mem_rvalid_i;

  assign ld_rvalid_o = (state_q == LD_RESP);
  assign ld_rdata_o  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LD_IDLE;
      req_q   <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        LD_IDLE: begin
          if (accept) begin
            state_q <= LD_LOOKUP;
          end
        end
        LD_LOOKUP: begin
          if (lk_hit_i) begin
            state_q <= LD_RESP;
          end else begin
            state_q <= LD_REFILL;
            req_q   <= 1'b1;
            beat_q  <= '0;
          end
        end
        LD_REFILL: begin
          if (refill_gnt_i) begin
            req_q <= 1'b0;
          end
          if (beat) begin
            beat_q <= beat_q + 1'b1;
          end
          if (refill_done_i) begin
            state_q <= LD_RESP;
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  // refilled word taken straight from the beat, no second lookup
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= ld_addr_i;
    end
    if (state_q == LD_LOOKUP) begin
      rdata_q <= lk_data_i;
    end else if (beat && (beat_q == addr_off(addr_q))) begin
      rdata_q <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ld_open_q <= 1'b0;
    end else if (accept) begin
      ld_open_q <= 1'b1;
    end else if (ld_rvalid_o) begin
      ld_open_q <= 1'b0;
    end
  end

  a_resp_needs_load : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_rvalid_o |-> ld_open_q)
    else $error("load response without an accepted load");

endmodule

// File: source/wtc_cache_mem.sv
`timescale 1ns/10ps

module wtc_cache_mem import wtc_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // registered lookup, load side
  input  idx_t            lk_idx_i,
  input  tag_t            lk_tag_i,
  input  off_t            lk_off_i,
  output logic            lk_hit_o,
  output word_t           lk_data_o,
  // combinational hit check, store side
  input  idx_t            sk_idx_i,
  input  tag_t            sk_tag_i,
  output logic            sk_hit_o,
  // single word write
  input  logic            word_we_i,
  input  idx_t            word_idx_i,
  input  off_t            word_off_i,
  input  word_t           word_data_i,
  input  logic [BE_W-1:0] word_be_i,
  // refill beats
  input  logic            refill_we_i,
  input  logic            refill_last_i,
  input  idx_t            refill_idx_i,
  input  tag_t            refill_tag_i,
  input  off_t            refill_off_i,
  input  word_t           refill_data_i,
  input  logic            flush_clr_i
);

  tag_t                 tag_q  [NUM_LINES];
  word_t                data_q [NUM_LINES][LINE_WORDS];
  logic [NUM_LINES-1:0] valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_clr_i) begin
      valid_q <= '0;
    end else if (refill_we_i) begin
      // invalid while beats arrive, valid again with the last one
      valid_q[refill_idx_i] <= refill_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_we_i && refill_last_i) begin
      tag_q[refill_idx_i] <= refill_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_we_i) begin
      data_q[refill_idx_i][refill_off_i] <= refill_data_i;
    end
    if (word_we_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (word_be_i[b]) begin
          data_q[word_idx_i][word_off_i][8*b +: 8] <= word_data_i[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lookups
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lk_hit_o <= 1'b0;
    end else begin
      lk_hit_o <= valid_q[lk_idx_i] && (tag_q[lk_idx_i] == lk_tag_i);
    end
  end

  always_ff @(posedge clk_i) begin
    lk_data_o <= data_q[lk_idx_i][lk_off_i];
  end

  // a line taking a refill beat this cycle never hits
  assign sk_hit_o = valid_q[sk_idx_i] && (tag_q[sk_idx_i] == sk_tag_i) &&
                    !(refill_we_i && (refill_idx_i == sk_idx_i));

  a_no_write_clash : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(word_we_i && refill_we_i && (word_idx_i == refill_idx_i)))
    else $error("store word write and refill hit the same line");

endmodule

// File: source/wtc_pkg.sv
package wtc_pkg;

  ////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 16;
  localparam int OFF_W      = $clog2(LINE_WORDS);
  localparam int IDX_W      = $clog2(NUM_LINES);
  // two byte-select bits sit below the word offset
  localparam int TAG_W      = ADDR_W - IDX_W - OFF_W - 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [OFF_W-1:0]  off_t;

  ////////////////////////////////////////////////////////////
  // address fields: tag | index | word offset | byte
  ////////////////////////////////////////////////////////////

  function automatic off_t addr_off(addr_t addr);
    return addr[OFF_W+1:2];
  endfunction

  function automatic idx_t addr_idx(addr_t addr);
    return addr[IDX_W+OFF_W+1:OFF_W+2];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_W-1:IDX_W+OFF_W+2];
  endfunction

  // first byte of the line holding addr
  function automatic addr_t line_base(addr_t addr);
    return {addr[ADDR_W-1:OFF_W+2], {(OFF_W+2){1'b0}}};
  endfunction

endpackage
